/* Makefile */
# Verilator build and run for the dispatch stage testbench
# any variable can be overridden, e.g. make run TOP=tb_dispatch LOG=run.log

VERILATOR ?= verilator
TOP ?= tb_dispatch
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/1ps
PASS_MSG ?= Simulation passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	rm -f $(LOG)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* core_pkg.sv */
`default_nettype none

package core_pkg;

	localparam int XLEN = 32;
	localparam int AREG_W = 5;
	localparam int FUNCT_W = 4;

	// queue tag fields are sized for the largest slot count
	localparam int RB_MAX = 8;
	localparam int TAG_MAX_W = AREG_W + $clog2(RB_MAX);

	typedef enum logic [2:0] {
		CLS_ALU = 3'd0,
		CLS_BRANCH = 3'd1,
		CLS_LOAD = 3'd2,
		CLS_STORE = 3'd3,
		CLS_FENCE = 3'd4,
		CLS_UNSUP = 3'd5
	} op_class_t;

	// tag is {areg, slot}
	function automatic int tag_w(input int rb);
		return AREG_W + $clog2(rb);
	endfunction

	typedef struct packed {
		op_class_t op;
		logic [FUNCT_W-1:0] funct;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [AREG_W-1:0] rd;
		logic [AREG_W-1:0] rs1;
		logic [AREG_W-1:0] rs2;
	} micro_instr_t;

	typedef struct packed {
		logic is_branch;
		logic [FUNCT_W-1:0] funct;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [TAG_MAX_W-1:0] rd_tag;
		logic [TAG_MAX_W-1:0] rs1_tag;
		logic [TAG_MAX_W-1:0] rs2_tag;
	} alu_entry_t;

	typedef struct packed {
		logic is_store;
		logic [FUNCT_W-1:0] funct;
		logic [XLEN-1:0] imm;
		logic [TAG_MAX_W-1:0] rd_tag;
		logic [TAG_MAX_W-1:0] rs1_tag;
		logic [TAG_MAX_W-1:0] rs2_tag;
	} lsu_entry_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic rd_en;
		logic [TAG_MAX_W-1:0] rd_tag;
	} rob_entry_t;

endpackage

`default_nettype wire

/* decode_ingress.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_ingress (
	input wire logic clk,
	input wire logic rst,
	input wire logic in_req,
	input wire core_pkg::op_class_t in_op,
	input wire logic [core_pkg::FUNCT_W-1:0] in_funct,
	input wire logic [core_pkg::XLEN-1:0] in_pc,
	input wire logic [core_pkg::XLEN-1:0] in_imm,
	input wire logic [core_pkg::AREG_W-1:0] in_rd,
	input wire logic [core_pkg::AREG_W-1:0] in_rs1,
	input wire logic [core_pkg::AREG_W-1:0] in_rs2,
	input wire logic fifo_full,
	output logic in_ack,
	output logic push,
	output core_pkg::micro_instr_t push_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACKED,
		ST_WAIT_LOW
	} state_t;

	state_t state;

	// req held through a full FIFO just waits in idle
	assign push = (state == ST_IDLE) & in_req & ~fifo_full;
	assign in_ack = (state == ST_ACKED);

	assign push_data = '{
		op: in_op,
		funct: in_funct,
		pc: in_pc,
		imm: in_imm,
		rd: in_rd,
		rs1: in_rs1,
		rs2: in_rs2
	};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (push) begin
						state <= ST_ACKED;
					end
				end
				ST_ACKED: begin
					if (!in_req) begin
						state <= ST_WAIT_LOW;
					end
				end
				// one guard cycle with ack low before the next req
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch #(
	parameter int RB = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire core_pkg::op_class_t head_op,
	input wire logic [core_pkg::FUNCT_W-1:0] head_funct,
	input wire logic [core_pkg::XLEN-1:0] head_pc,
	input wire logic [core_pkg::XLEN-1:0] head_imm,
	input wire logic [core_pkg::AREG_W-1:0] head_rd,
	input wire logic [core_pkg::AREG_W-1:0] head_rs1,
	input wire logic [core_pkg::AREG_W-1:0] head_rs2,
	input wire logic head_valid,
	input wire logic alu_full,
	input wire logic lsu_full,
	input wire logic lsu_empty,
	input wire logic rob_full,
	input wire logic free_en,
	input wire logic [core_pkg::tag_w(RB)-1:0] free_tag,
	output logic iq_pop,
	output logic alu_push,
	output logic alu_is_branch,
	output logic [core_pkg::FUNCT_W-1:0] alu_funct,
	output logic [core_pkg::XLEN-1:0] alu_pc,
	output logic [core_pkg::XLEN-1:0] alu_imm,
	output logic [core_pkg::TAG_MAX_W-1:0] alu_rd_tag,
	output logic [core_pkg::TAG_MAX_W-1:0] alu_rs1_tag,
	output logic [core_pkg::TAG_MAX_W-1:0] alu_rs2_tag,
	output logic lsu_push,
	output logic lsu_is_store,
	output logic [core_pkg::FUNCT_W-1:0] lsu_funct,
	output logic [core_pkg::XLEN-1:0] lsu_imm,
	output logic [core_pkg::TAG_MAX_W-1:0] lsu_rd_tag,
	output logic [core_pkg::TAG_MAX_W-1:0] lsu_rs1_tag,
	output logic [core_pkg::TAG_MAX_W-1:0] lsu_rs2_tag,
	output logic rob_push,
	output logic [core_pkg::XLEN-1:0] rob_pc,
	output logic rob_rd_en,
	output logic [core_pkg::TAG_MAX_W-1:0] rob_rd_tag
);

	localparam int TW = core_pkg::tag_w(RB);
	localparam int TMW = core_pkg::TAG_MAX_W;

	logic [TW-1:0] rs1_tag;
	logic [TW-1:0] rs2_tag;
	logic [TW-1:0] rd_tag;
	logic rd_run_out;
	logic rd_alloc;

	logic is_int;
	logic is_mem;
	logic is_fence;
	logic is_unsup;
	logic has_rd;
	logic can_go;
	logic [TMW-1:0] rd_tag_ext;

	assign is_int = (head_op == core_pkg::CLS_ALU) | (head_op == core_pkg::CLS_BRANCH);
	assign is_mem = (head_op == core_pkg::CLS_LOAD) | (head_op == core_pkg::CLS_STORE);
	assign is_fence = (head_op == core_pkg::CLS_FENCE);
	// unknown codes are dropped like unsupported ones
	assign is_unsup = ~is_int & ~is_mem & ~is_fence;

	// branches and stores write no register
	assign has_rd = ((head_op == core_pkg::CLS_ALU) | (head_op == core_pkg::CLS_LOAD))
		& (head_rd != '0);

	assign can_go = head_valid & ~rob_full & ~(has_rd & rd_run_out);

	assign alu_push = can_go & is_int & ~alu_full;
	assign lsu_push = can_go & is_mem & ~lsu_full;
	assign rob_push = alu_push | lsu_push;
	assign rd_alloc = rob_push & has_rd;

	// fence waits for an empty memory queue, then leaves with no reorder entry
	assign iq_pop = rob_push
		| (head_valid & is_fence & lsu_empty)
		| (head_valid & is_unsup);

	assign rd_tag_ext = has_rd ? TMW'(rd_tag) : '0;

	assign alu_is_branch = (head_op == core_pkg::CLS_BRANCH);
	assign alu_funct = head_funct;
	assign alu_pc = head_pc;
	assign alu_imm = head_imm;
	assign alu_rd_tag = rd_tag_ext;
	assign alu_rs1_tag = TMW'(rs1_tag);
	assign alu_rs2_tag = TMW'(rs2_tag);

	assign lsu_is_store = (head_op == core_pkg::CLS_STORE);
	assign lsu_funct = head_funct;
	assign lsu_imm = head_imm;
	assign lsu_rd_tag = rd_tag_ext;
	assign lsu_rs1_tag = TMW'(rs1_tag);
	assign lsu_rs2_tag = TMW'(rs2_tag);

	assign rob_pc = head_pc;
	assign rob_rd_en = has_rd;
	assign rob_rd_tag = rd_tag_ext;

	rename #(
		.RB(RB)
	) u_rename (
		.clk(clk),
		.rst(rst),
		.rs1(head_rs1),
		.rs2(head_rs2),
		.rd(head_rd),
		.rd_alloc(rd_alloc),
		.free_en(free_en),
		.free_tag(free_tag),
		.rs1_tag(rs1_tag),
		.rs2_tag(rs2_tag),
		.rd_tag(rd_tag),
		.rd_run_out(rd_run_out)
	);

endmodule

`default_nettype wire

/* dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_top #(
	parameter int RB = 4,
	parameter int IQ_DEPTH = 4,
	parameter int ALU_DEPTH = 4,
	parameter int LSU_DEPTH = 4,
	parameter int ROB_DEPTH = 8
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic in_req,
	input wire core_pkg::op_class_t in_op,
	input wire logic [core_pkg::FUNCT_W-1:0] in_funct,
	input wire logic [core_pkg::XLEN-1:0] in_pc,
	input wire logic [core_pkg::XLEN-1:0] in_imm,
	input wire logic [core_pkg::AREG_W-1:0] in_rd,
	input wire logic [core_pkg::AREG_W-1:0] in_rs1,
	input wire logic [core_pkg::AREG_W-1:0] in_rs2,
	output logic in_ack,
	output logic alu_valid,
	input wire logic alu_pop,
	output logic alu_is_branch,
	output logic [core_pkg::FUNCT_W-1:0] alu_funct,
	output logic [core_pkg::XLEN-1:0] alu_pc,
	output logic [core_pkg::XLEN-1:0] alu_imm,
	output logic [core_pkg::TAG_MAX_W-1:0] alu_rd_tag,
	output logic [core_pkg::TAG_MAX_W-1:0] alu_rs1_tag,
	output logic [core_pkg::TAG_MAX_W-1:0] alu_rs2_tag,
	output logic lsu_valid,
	input wire logic lsu_pop,
	output logic lsu_is_store,
	output logic [core_pkg::FUNCT_W-1:0] lsu_funct,
	output logic [core_pkg::XLEN-1:0] lsu_imm,
	output logic [core_pkg::TAG_MAX_W-1:0] lsu_rd_tag,
	output logic [core_pkg::TAG_MAX_W-1:0] lsu_rs1_tag,
	output logic [core_pkg::TAG_MAX_W-1:0] lsu_rs2_tag,
	output logic commit_req,
	input wire logic commit_ack,
	output logic [core_pkg::XLEN-1:0] commit_pc,
	output logic commit_rd_en,
	output logic [core_pkg::TAG_MAX_W-1:0] commit_rd_tag
);

	// instruction FIFO
	logic iq_push;
	logic iq_pop;
	logic iq_full;
	logic iq_not_empty;
	core_pkg::micro_instr_t iq_data;
	core_pkg::micro_instr_t iq_head;

	// issue and reorder queues
	logic alu_push;
	logic alu_full;
	core_pkg::alu_entry_t alu_data;
	core_pkg::alu_entry_t alu_head;
	logic lsu_push;
	logic lsu_full;
	logic lsu_empty;
	core_pkg::lsu_entry_t lsu_data;
	core_pkg::lsu_entry_t lsu_head;
	logic rob_push;
	logic rob_pop;
	logic rob_full;
	logic rob_not_empty;
	core_pkg::rob_entry_t rob_data;
	core_pkg::rob_entry_t rob_head;

	logic free_en;
	logic [core_pkg::tag_w(RB)-1:0] free_tag;

	assign alu_is_branch = alu_head.is_branch;
	assign alu_funct = alu_head.funct;
	assign alu_pc = alu_head.pc;
	assign alu_imm = alu_head.imm;
	assign alu_rd_tag = alu_head.rd_tag;
	assign alu_rs1_tag = alu_head.rs1_tag;
	assign alu_rs2_tag = alu_head.rs2_tag;

	assign lsu_is_store = lsu_head.is_store;
	assign lsu_funct = lsu_head.funct;
	assign lsu_imm = lsu_head.imm;
	assign lsu_rd_tag = lsu_head.rd_tag;
	assign lsu_rs1_tag = lsu_head.rs1_tag;
	assign lsu_rs2_tag = lsu_head.rs2_tag;

	decode_ingress u_ingress (
		.clk(clk),
		.rst(rst),
		.in_req(in_req),
		.in_op(in_op),
		.in_funct(in_funct),
		.in_pc(in_pc),
		.in_imm(in_imm),
		.in_rd(in_rd),
		.in_rs1(in_rs1),
		.in_rs2(in_rs2),
		.fifo_full(iq_full),
		.in_ack(in_ack),
		.push(iq_push),
		.push_data(iq_data)
	);

	sync_fifo #(
		.T(core_pkg::micro_instr_t),
		.DEPTH(IQ_DEPTH)
	) u_iq (
		.clk(clk),
		.rst(rst),
		.push(iq_push),
		.push_data(iq_data),
		.pop(iq_pop),
		.head(iq_head),
		.not_empty(iq_not_empty),
		.full(iq_full),
		.empty()
	);

	dispatch #(
		.RB(RB)
	) u_dispatch (
		.clk(clk),
		.rst(rst),
		.head_op(iq_head.op),
		.head_funct(iq_head.funct),
		.head_pc(iq_head.pc),
		.head_imm(iq_head.imm),
		.head_rd(iq_head.rd),
		.head_rs1(iq_head.rs1),
		.head_rs2(iq_head.rs2),
		.head_valid(iq_not_empty),
		.alu_full(alu_full),
		.lsu_full(lsu_full),
		.lsu_empty(lsu_empty),
		.rob_full(rob_full),
		.free_en(free_en),
		.free_tag(free_tag),
		.iq_pop(iq_pop),
		.alu_push(alu_push),
		.alu_is_branch(alu_data.is_branch),
		.alu_funct(alu_data.funct),
		.alu_pc(alu_data.pc),
		.alu_imm(alu_data.imm),
		.alu_rd_tag(alu_data.rd_tag),
		.alu_rs1_tag(alu_data.rs1_tag),
		.alu_rs2_tag(alu_data.rs2_tag),
		.lsu_push(lsu_push),
		.lsu_is_store(lsu_data.is_store),
		.lsu_funct(lsu_data.funct),
		.lsu_imm(lsu_data.imm),
		.lsu_rd_tag(lsu_data.rd_tag),
		.lsu_rs1_tag(lsu_data.rs1_tag),
		.lsu_rs2_tag(lsu_data.rs2_tag),
		.rob_push(rob_push),
		.rob_pc(rob_data.pc),
		.rob_rd_en(rob_data.rd_en),
		.rob_rd_tag(rob_data.rd_tag)
	);

	sync_fifo #(
		.T(core_pkg::alu_entry_t),
		.DEPTH(ALU_DEPTH)
	) u_alu_q (
		.clk(clk),
		.rst(rst),
		.push(alu_push),
		.push_data(alu_data),
		.pop(alu_pop),
		.head(alu_head),
		.not_empty(alu_valid),
		.full(alu_full),
		.empty()
	);

	sync_fifo #(
		.T(core_pkg::lsu_entry_t),
		.DEPTH(LSU_DEPTH)
	) u_lsu_q (
		.clk(clk),
		.rst(rst),
		.push(lsu_push),
		.push_data(lsu_data),
		.pop(lsu_pop),
		.head(lsu_head),
		.not_empty(lsu_valid),
		.full(lsu_full),
		.empty(lsu_empty)
	);

	sync_fifo #(
		.T(core_pkg::rob_entry_t),
		.DEPTH(ROB_DEPTH)
	) u_rob (
		.clk(clk),
		.rst(rst),
		.push(rob_push),
		.push_data(rob_data),
		.pop(rob_pop),
		.head(rob_head),
		.not_empty(rob_not_empty),
		.full(rob_full),
		.empty()
	);

	retire_unit #(
		.RB(RB)
	) u_retire (
		.clk(clk),
		.rst(rst),
		.rob_pc(rob_head.pc),
		.rob_rd_en(rob_head.rd_en),
		.rob_rd_tag(rob_head.rd_tag),
		.rob_not_empty(rob_not_empty),
		.commit_ack(commit_ack),
		.rob_pop(rob_pop),
		.commit_req(commit_req),
		.commit_pc(commit_pc),
		.commit_rd_en(commit_rd_en),
		.commit_rd_tag(commit_rd_tag),
		.free_en(free_en),
		.free_tag(free_tag)
	);

endmodule

`default_nettype wire

/* rename.sv */
`timescale 1ns/1ps
`default_nettype none

module rename #(
	parameter int RB = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [core_pkg::AREG_W-1:0] rs1,
	input wire logic [core_pkg::AREG_W-1:0] rs2,
	input wire logic [core_pkg::AREG_W-1:0] rd,
	input wire logic rd_alloc,
	input wire logic free_en,
	input wire logic [core_pkg::tag_w(RB)-1:0] free_tag,
	output logic [core_pkg::tag_w(RB)-1:0] rs1_tag,
	output logic [core_pkg::tag_w(RB)-1:0] rs2_tag,
	output logic [core_pkg::tag_w(RB)-1:0] rd_tag,
	output logic rd_run_out
);

	localparam int SW = $clog2(RB);
	localparam int TW = core_pkg::tag_w(RB);
	localparam int NREG = 2 ** core_pkg::AREG_W;

	// per register slot-used bits and the slot readers see
	logic [RB-1:0] used [NREG];
	logic [SW-1:0] active [NREG];

	logic [SW-1:0] free_slot;
	logic [core_pkg::AREG_W-1:0] free_reg;
	logic [SW-1:0] free_idx;

	// lowest free slot of rd
	always_comb begin
		free_slot = '0;
		for (int i = RB - 1; i >= 0; i--) begin
			if (!used[rd][i]) begin
				free_slot = SW'(i);
			end
		end
	end

	assign rd_run_out = &used[rd];
	assign rd_tag = {rd, free_slot};
	assign rs1_tag = {rs1, active[rs1]};
	assign rs2_tag = {rs2, active[rs2]};

	assign free_reg = free_tag[TW-1:SW];
	assign free_idx = free_tag[SW-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < NREG; r++) begin
				used[r] <= '0;
				active[r] <= '0;
			end
		end else begin
			if (free_en) begin
				used[free_reg][free_idx] <= 1'b0;
			end
			// allocation only ever picks a slot that is already free
			if (rd_alloc && !rd_run_out) begin
				used[rd][free_slot] <= 1'b1;
				active[rd] <= free_slot;
			end
		end
	end

endmodule

`default_nettype wire

/* retire_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_unit #(
	parameter int RB = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic [core_pkg::XLEN-1:0] rob_pc,
	input wire logic rob_rd_en,
	input wire logic [core_pkg::TAG_MAX_W-1:0] rob_rd_tag,
	input wire logic rob_not_empty,
	input wire logic commit_ack,
	output logic rob_pop,
	output logic commit_req,
	output logic [core_pkg::XLEN-1:0] commit_pc,
	output logic commit_rd_en,
	output logic [core_pkg::TAG_MAX_W-1:0] commit_rd_tag,
	output logic free_en,
	output logic [core_pkg::tag_w(RB)-1:0] free_tag
);

	localparam int TW = core_pkg::tag_w(RB);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT_LOW
	} state_t;

	state_t state;

	assign rob_pop = (state == ST_IDLE) & rob_not_empty;
	assign commit_req = (state == ST_REQ);

	// ack means the execution side is done with it
	assign free_en = (state == ST_REQ) & commit_ack & commit_rd_en;
	assign free_tag = commit_rd_tag[TW-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (rob_not_empty) begin
						state <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (commit_ack) begin
						state <= ST_WAIT_LOW;
					end
				end
				default: begin
					if (!commit_ack) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// popped entry held for the whole handshake
	always_ff @(posedge clk) begin
		if (rob_pop) begin
			commit_pc <= rob_pc;
			commit_rd_en <= rob_rd_en;
			commit_rd_tag <= rob_rd_tag;
		end
	end

endmodule

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type T = logic [7:0],
	parameter int DEPTH = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic push,
	input wire T push_data,
	input wire logic pop,
	output T head,
	output logic not_empty,
	output logic full,
	output logic empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	T mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW-1:0] wr_ptr_nxt;
	logic [AW-1:0] rd_ptr_nxt;
	logic [CW-1:0] count;
	logic push_ok;
	logic pop_ok;

	assign push_ok = push & ~full;
	assign pop_ok = pop & ~empty;
	assign empty = (count == '0);
	assign not_empty = ~empty;
	assign full = (count == CW'(DEPTH));

	// explicit wrap so any depth works
	assign wr_ptr_nxt = (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
	assign rd_ptr_nxt = (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr_nxt;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr_nxt;
			end
			if (push_ok && !pop_ok) begin
				count <= count + CW'(1);
			end else if (pop_ok && !push_ok) begin
				count <= count - CW'(1);
			end
		end
	end

	// head register follows the oldest entry
	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_data;
		end
		if (pop_ok) begin
			if (count == CW'(1)) begin
				head <= push_data;
			end else begin
				head <= mem[rd_ptr_nxt];
			end
		end else if (empty && push_ok) begin
			head <= push_data;
		end
	end

endmodule

`default_nettype wire

/* tb_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch;

	localparam int RB = 4;
	localparam int IQ_DEPTH = 4;
	localparam int ALU_DEPTH = 4;
	localparam int LSU_DEPTH = 4;
	localparam int ROB_DEPTH = 8;
	localparam int SW = $clog2(RB);
	localparam int TW = core_pkg::TAG_MAX_W;
	localparam int RESET_CYCLES = 16;
	// instructions sent over all tests, 200 cycles allowed for each
	localparam int N_SENT = 34;
	localparam int WATCHDOG_CYCLES = N_SENT * 200 + RESET_CYCLES;

	logic clk;
	logic rst;
	logic in_req;
	core_pkg::op_class_t in_op;
	logic [3:0] in_funct;
	logic [31:0] in_pc;
	logic [31:0] in_imm;
	logic [4:0] in_rd;
	logic [4:0] in_rs1;
	logic [4:0] in_rs2;
	logic in_ack;
	logic alu_valid;
	logic alu_pop;
	logic alu_is_branch;
	logic [3:0] alu_funct;
	logic [31:0] alu_pc;
	logic [31:0] alu_imm;
	logic [TW-1:0] alu_rd_tag;
	logic [TW-1:0] alu_rs1_tag;
	logic [TW-1:0] alu_rs2_tag;
	logic lsu_valid;
	logic lsu_pop;
	logic lsu_is_store;
	logic [3:0] lsu_funct;
	logic [31:0] lsu_imm;
	logic [TW-1:0] lsu_rd_tag;
	logic [TW-1:0] lsu_rs1_tag;
	logic [TW-1:0] lsu_rs2_tag;
	logic commit_req;
	logic commit_ack;
	logic [31:0] commit_pc;
	logic commit_rd_en;
	logic [TW-1:0] commit_rd_tag;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	logic [31:0] lfsr = 32'h6190;

	// slot model, same rules as the rename tables
	logic [RB-1:0] model_used [32];
	logic [SW-1:0] model_active [32];

	core_pkg::alu_entry_t alu_q [$];
	core_pkg::lsu_entry_t lsu_q [$];
	core_pkg::rob_entry_t rob_q [$];

	dispatch_top #(
		.RB(RB),
		.IQ_DEPTH(IQ_DEPTH),
		.ALU_DEPTH(ALU_DEPTH),
		.LSU_DEPTH(LSU_DEPTH),
		.ROB_DEPTH(ROB_DEPTH)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.in_req(in_req),
		.in_op(in_op),
		.in_funct(in_funct),
		.in_pc(in_pc),
		.in_imm(in_imm),
		.in_rd(in_rd),
		.in_rs1(in_rs1),
		.in_rs2(in_rs2),
		.in_ack(in_ack),
		.alu_valid(alu_valid),
		.alu_pop(alu_pop),
		.alu_is_branch(alu_is_branch),
		.alu_funct(alu_funct),
		.alu_pc(alu_pc),
		.alu_imm(alu_imm),
		.alu_rd_tag(alu_rd_tag),
		.alu_rs1_tag(alu_rs1_tag),
		.alu_rs2_tag(alu_rs2_tag),
		.lsu_valid(lsu_valid),
		.lsu_pop(lsu_pop),
		.lsu_is_store(lsu_is_store),
		.lsu_funct(lsu_funct),
		.lsu_imm(lsu_imm),
		.lsu_rd_tag(lsu_rd_tag),
		.lsu_rs1_tag(lsu_rs1_tag),
		.lsu_rs2_tag(lsu_rs2_tag),
		.commit_req(commit_req),
		.commit_ack(commit_ack),
		.commit_pc(commit_pc),
		.commit_rd_en(commit_rd_en),
		.commit_rd_tag(commit_rd_tag)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		// taps 32, 22, 2, 1
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [TW-1:0] make_tag(input logic [4:0] areg, input int slot);
		return (TW'(areg) << SW) | TW'(slot);
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
		checks++;
		if (got !== want) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	// expected queue entries for one instruction, allocating its slot in the model
	task automatic predict_dispatch(input core_pkg::op_class_t op, input logic [3:0] funct,
		input logic [31:0] pc, input logic [31:0] imm, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		core_pkg::alu_entry_t a;
		core_pkg::lsu_entry_t l;
		core_pkg::rob_entry_t r;
		logic has_rd;
		logic [TW-1:0] rd_tag;
		int slot;
		has_rd = (op == core_pkg::CLS_ALU || op == core_pkg::CLS_LOAD) && rd != 5'd0;
		rd_tag = '0;
		if (has_rd) begin
			slot = -1;
			for (int i = RB - 1; i >= 0; i--) begin
				if (!model_used[rd][i]) begin
					slot = i;
				end
			end
			if (slot < 0) begin
				$display("test setup error: x%0d has no free rename slot to predict", rd);
				errors++;
			end else begin
				rd_tag = make_tag(rd, slot);
			end
		end
		// sources read the active slot before this write
		a.is_branch = (op == core_pkg::CLS_BRANCH);
		a.funct = funct;
		a.pc = pc;
		a.imm = imm;
		a.rd_tag = rd_tag;
		a.rs1_tag = make_tag(rs1, int'(model_active[rs1]));
		a.rs2_tag = make_tag(rs2, int'(model_active[rs2]));
		l.is_store = (op == core_pkg::CLS_STORE);
		l.funct = funct;
		l.imm = imm;
		l.rd_tag = rd_tag;
		l.rs1_tag = a.rs1_tag;
		l.rs2_tag = a.rs2_tag;
		r.pc = pc;
		r.rd_en = has_rd;
		r.rd_tag = rd_tag;
		if (has_rd && slot >= 0) begin
			model_used[rd][slot] = 1'b1;
			model_active[rd] = SW'(slot);
		end
		if (op == core_pkg::CLS_ALU || op == core_pkg::CLS_BRANCH) begin
			alu_q.push_back(a);
			rob_q.push_back(r);
		end else if (op == core_pkg::CLS_LOAD || op == core_pkg::CLS_STORE) begin
			lsu_q.push_back(l);
			rob_q.push_back(r);
		end
	endtask

	task automatic send_instr(input core_pkg::op_class_t op, input logic [3:0] funct,
		input logic [31:0] pc, input logic [31:0] imm, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		@(posedge clk);
		in_op <= op;
		in_funct <= funct;
		in_pc <= pc;
		in_imm <= imm;
		in_rd <= rd;
		in_rs1 <= rs1;
		in_rs2 <= rs2;
		in_req <= 1'b1;
		do begin
			@(negedge clk);
		end while (!in_ack);
		@(posedge clk);
		in_req <= 1'b0;
		do begin
			@(negedge clk);
		end while (in_ack);
	endtask

	task automatic issue_instr(input core_pkg::op_class_t op, input logic [3:0] funct,
		input logic [31:0] pc, input logic [31:0] imm, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		predict_dispatch(op, funct, pc, imm, rd, rs1, rs2);
		send_instr(op, funct, pc, imm, rd, rs1, rs2);
	endtask

	task automatic pop_alu();
		core_pkg::alu_entry_t want;
		do begin
			@(negedge clk);
		end while (!alu_valid);
		if (alu_q.size() == 0) begin
			$display("integer queue offered an entry that no instruction should have made");
			errors++;
		end else begin
			want = alu_q.pop_front();
			check("alu_is_branch", 64'(alu_is_branch), 64'(want.is_branch));
			check("alu_funct", 64'(alu_funct), 64'(want.funct));
			check("alu_pc", 64'(alu_pc), 64'(want.pc));
			check("alu_imm", 64'(alu_imm), 64'(want.imm));
			check("alu_rd_tag", 64'(alu_rd_tag), 64'(want.rd_tag));
			check("alu_rs1_tag", 64'(alu_rs1_tag), 64'(want.rs1_tag));
			check("alu_rs2_tag", 64'(alu_rs2_tag), 64'(want.rs2_tag));
		end
		@(posedge clk);
		alu_pop <= 1'b1;
		@(posedge clk);
		alu_pop <= 1'b0;
	endtask

	task automatic pop_lsu();
		core_pkg::lsu_entry_t want;
		do begin
			@(negedge clk);
		end while (!lsu_valid);
		if (lsu_q.size() == 0) begin
			$display("memory queue offered an entry that no instruction should have made");
			errors++;
		end else begin
			want = lsu_q.pop_front();
			check("lsu_is_store", 64'(lsu_is_store), 64'(want.is_store));
			check("lsu_funct", 64'(lsu_funct), 64'(want.funct));
			check("lsu_imm", 64'(lsu_imm), 64'(want.imm));
			check("lsu_rd_tag", 64'(lsu_rd_tag), 64'(want.rd_tag));
			check("lsu_rs1_tag", 64'(lsu_rs1_tag), 64'(want.rs1_tag));
			check("lsu_rs2_tag", 64'(lsu_rs2_tag), 64'(want.rs2_tag));
		end
		@(posedge clk);
		lsu_pop <= 1'b1;
		@(posedge clk);
		lsu_pop <= 1'b0;
	endtask

	// answer one commit after 0 to 7 random cycles
	task automatic do_commit();
		core_pkg::rob_entry_t want;
		int wait_cycles;
		do begin
			@(negedge clk);
		end while (!commit_req);
		if (rob_q.size() == 0) begin
			$display("commit request arrived with no dispatched instruction left to commit");
			errors++;
		end else begin
			want = rob_q.pop_front();
			check("commit_pc", 64'(commit_pc), 64'(want.pc));
			check("commit_rd_en", 64'(commit_rd_en), 64'(want.rd_en));
			check("commit_rd_tag", 64'(commit_rd_tag), 64'(want.rd_tag));
			if (want.rd_en) begin
				model_used[want.rd_tag[SW+4:SW]][want.rd_tag[SW-1:0]] = 1'b0;
			end
		end
		wait_cycles = 0;
		for (int i = 0; i < 3; i++) begin
			lfsr = lfsr_step(lfsr);
			wait_cycles = (wait_cycles << 1) | int'(lfsr[0]);
		end
		repeat (wait_cycles) @(posedge clk);
		@(posedge clk);
		commit_ack <= 1'b1;
		do begin
			@(negedge clk);
		end while (commit_req);
		@(posedge clk);
		commit_ack <= 1'b0;
	endtask

	task automatic drain_commits();
		while (rob_q.size() > 0) begin
			do_commit();
		end
	endtask

	// nothing left anywhere, and no stray commit
	task automatic expect_idle();
		repeat (8) @(negedge clk);
		check("commit_req when idle", 64'(commit_req), 64'd0);
		check("alu_valid when idle", 64'(alu_valid), 64'd0);
		check("lsu_valid when idle", 64'(lsu_valid), 64'd0);
	endtask

	task automatic test_reset();
		int err0;
		err0 = errors;
		@(negedge clk);
		check("in_ack after reset", 64'(in_ack), 64'd0);
		check("commit_req after reset", 64'(commit_req), 64'd0);
		check("alu_valid after reset", 64'(alu_valid), 64'd0);
		check("lsu_valid after reset", 64'(lsu_valid), 64'd0);
		report_test("reset", err0);
	endtask

	task automatic test_routing();
		int err0;
		err0 = errors;
		issue_instr(core_pkg::CLS_ALU, 4'h3, 32'h0000_1000, 32'h0000_0011, 5'd1, 5'd2, 5'd3);
		issue_instr(core_pkg::CLS_BRANCH, 4'h6, 32'h0000_1004, 32'hFFFF_FFF0, 5'd4, 5'd1, 5'd2);
		issue_instr(core_pkg::CLS_LOAD, 4'h2, 32'h0000_1008, 32'h0000_0040, 5'd8, 5'd2, 5'd0);
		issue_instr(core_pkg::CLS_STORE, 4'h1, 32'h0000_100C, 32'h0000_0044, 5'd0, 5'd8, 5'd1);
		pop_alu();
		pop_alu();
		pop_lsu();
		pop_lsu();
		drain_commits();
		expect_idle();
		report_test("routing", err0);
	endtask

	task automatic test_renaming();
		int err0;
		err0 = errors;
		issue_instr(core_pkg::CLS_ALU, 4'h0, 32'h0000_2000, 32'h0000_0001, 5'd5, 5'd1, 5'd0);
		issue_instr(core_pkg::CLS_ALU, 4'h0, 32'h0000_2004, 32'h0000_0002, 5'd6, 5'd5, 5'd5);
		issue_instr(core_pkg::CLS_ALU, 4'h0, 32'h0000_2008, 32'h0000_0003, 5'd5, 5'd6, 5'd0);
		// reader after the second writer sees slot 1
		issue_instr(core_pkg::CLS_ALU, 4'h0, 32'h0000_200C, 32'h0000_0004, 5'd6, 5'd5, 5'd0);
		pop_alu();
		pop_alu();
		pop_alu();
		pop_alu();
		drain_commits();
		expect_idle();
		report_test("renaming", err0);
	endtask

	task automatic test_exhaustion();
		int err0;
		logic seen;
		err0 = errors;
		for (int i = 0; i < RB; i++) begin
			issue_instr(core_pkg::CLS_ALU, 4'h5, 32'h0000_3000 + 32'(i * 4), 32'(i),
				5'd7, 5'd1, 5'd2);
		end
		repeat (RB) pop_alu();
		send_instr(core_pkg::CLS_ALU, 4'h5, 32'h0000_3010, 32'h0000_0099, 5'd7, 5'd1, 5'd2);
		seen = 1'b0;
		repeat (20) begin
			@(negedge clk);
			seen = seen | alu_valid;
		end
		check("alu_valid with x7 slots used up", 64'(seen), 64'd0);
		do_commit();
		// the freed slot goes to the waiting writer
		predict_dispatch(core_pkg::CLS_ALU, 4'h5, 32'h0000_3010, 32'h0000_0099, 5'd7, 5'd1, 5'd2);
		pop_alu();
		drain_commits();
		expect_idle();
		report_test("slot exhaustion", err0);
	endtask

	task automatic test_fence_drop();
		int err0;
		logic seen;
		err0 = errors;
		issue_instr(core_pkg::CLS_LOAD, 4'h2, 32'h0000_4000, 32'h0000_0080, 5'd9, 5'd3, 5'd0);
		send_instr(core_pkg::CLS_FENCE, 4'h0, 32'h0000_4004, 32'h0, 5'd0, 5'd0, 5'd0);
		issue_instr(core_pkg::CLS_ALU, 4'h4, 32'h0000_4008, 32'h0000_0005, 5'd10, 5'd9, 5'd0);
		seen = 1'b0;
		repeat (20) begin
			@(negedge clk);
			seen = seen | alu_valid;
		end
		check("alu_valid behind fence", 64'(seen), 64'd0);
		pop_lsu();
		pop_alu();
		send_instr(core_pkg::CLS_UNSUP, 4'h0, 32'h0000_400C, 32'h0, 5'd3, 5'd0, 5'd0);
		issue_instr(core_pkg::CLS_ALU, 4'h7, 32'h0000_4010, 32'h0000_0006, 5'd11, 5'd10, 5'd9);
		pop_alu();
		drain_commits();
		expect_idle();
		report_test("fence and drop", err0);
	endtask

	task automatic test_backpressure();
		int err0;
		int accepted;
		err0 = errors;
		accepted = 0;
		fork
			begin
				for (int i = 0; i < 10; i++) begin
					issue_instr(core_pkg::CLS_ALU, 4'(i), 32'h0000_5000 + 32'(i * 4),
						32'h100 + 32'(i), 5'(10 + i), 5'd1, 5'd2);
					accepted++;
				end
			end
			begin
				// queue and FIFO full, the next send stays unacked
				repeat (100) @(posedge clk);
				check("instructions accepted while stalled", 64'(accepted),
					64'(ALU_DEPTH + IQ_DEPTH));
				repeat (10) pop_alu();
			end
			begin
				repeat (10) do_commit();
			end
		join
		expect_idle();
		report_test("back-pressure", err0);
	endtask

	task automatic test_commit_order();
		int err0;
		err0 = errors;
		issue_instr(core_pkg::CLS_ALU, 4'h1, 32'h0000_6000, 32'h0000_0010, 5'd12, 5'd5, 5'd7);
		issue_instr(core_pkg::CLS_LOAD, 4'h2, 32'h0000_6004, 32'h0000_0020, 5'd12, 5'd12, 5'd0);
		issue_instr(core_pkg::CLS_STORE, 4'h3, 32'h0000_6008, 32'h0000_0030, 5'd0, 5'd12, 5'd3);
		issue_instr(core_pkg::CLS_BRANCH, 4'h4, 32'h0000_600C, 32'h0000_0040, 5'd0, 5'd12, 5'd0);
		issue_instr(core_pkg::CLS_ALU, 4'h5, 32'h0000_6010, 32'h0000_0050, 5'd13, 5'd12, 5'd6);
		issue_instr(core_pkg::CLS_ALU, 4'h6, 32'h0000_6014, 32'h0000_0060, 5'd0, 5'd13, 5'd12);
		repeat (4) pop_alu();
		repeat (2) pop_lsu();
		drain_commits();
		expect_idle();
		report_test("commit order", err0);
	endtask

	initial begin
		rst = 1'b1;
		in_req = 1'b0;
		in_op = core_pkg::CLS_ALU;
		in_funct = '0;
		in_pc = '0;
		in_imm = '0;
		in_rd = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		alu_pop = 1'b0;
		lsu_pop = 1'b0;
		commit_ack = 1'b0;
		for (int r = 0; r < 32; r++) begin
			model_used[r] = '0;
			model_active[r] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_routing();
		test_renaming();
		test_exhaustion();
		test_fence_drop();
		test_backpressure();
		test_commit_order();
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
core_pkg.sv
sync_fifo.sv
decode_ingress.sv
rename.sv
dispatch.sv
retire_unit.sv
dispatch_top.sv
tb_dispatch.sv
